// ==== common/core_pkg.sv ====
// ====================
// core_pkg
// data and register widths, RV32I major opcodes,
// ALU operation codes and the pipeline records
// ====================
package core_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;

  typedef logic [xlen-1:0] xlen_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [31:0] inst_t;

  // kept major opcodes
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui = 7'b0110111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // decoded instruction, decode to execute
  typedef struct packed {
    alu_op_e alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic use_imm;
    logic wen;
    xlen_t op_a;
    xlen_t op_b;
    inst_t inst;
  } uop_t;

  // retired instruction on the commit port
  typedef struct packed {
    logic wen;
    reg_addr_t rd;
    xlen_t data;
    inst_t inst;
  } commit_t;

  typedef struct packed {
    logic en;
    reg_addr_t addr;
    xlen_t data;
  } reg_write_t;

endpackage

// ==== logic/alu.sv ====
// ====================
// alu
// combinational RV32I integer ALU
// ====================
`timescale 1ns/10ps

module alu (
  input  core_pkg::alu_op_e alu_op,
  input  core_pkg::xlen_t a,
  input  core_pkg::xlen_t b,
  output core_pkg::xlen_t result
);

  logic [4:0] shamt;

  // only the low five bits shift
  assign shamt = b[4:0];

  always_comb begin
    result = '0;
    case (alu_op)
      core_pkg::alu_add: begin
        result = a + b;
      end
      core_pkg::alu_sub: begin
        result = a - b;
      end
      core_pkg::alu_sll: begin
        result = a << shamt;
      end
      core_pkg::alu_slt: begin
        result = {{(core_pkg::xlen-1){1'b0}}, ($signed(a) < $signed(b))};
      end
      core_pkg::alu_sltu: begin
        result = {{(core_pkg::xlen-1){1'b0}}, (a < b)};
      end
      core_pkg::alu_xor: begin
        result = a ^ b;
      end
      core_pkg::alu_srl: begin
        result = a >> shamt;
      end
      core_pkg::alu_sra: begin
        result = $signed(a) >>> shamt;
      end
      core_pkg::alu_or: begin
        result = a | b;
      end
      core_pkg::alu_and: begin
        result = a & b;
      end
      core_pkg::alu_pass_b: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// ==== logic/regfile.sv ====
// ====================
// regfile
// 32 x 32 integer registers, x0 tied to zero,
// two read ports with write-to-read bypass
// ====================
`timescale 1ns/10ps

module regfile (
  input  logic clock,
  input  logic reset,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::xlen_t rs1_data,
  output core_pkg::xlen_t rs2_data,
  input  core_pkg::reg_write_t reg_write
);

  // x0 has no storage
  core_pkg::xlen_t regs [1:core_pkg::reg_count-1];

  function automatic core_pkg::xlen_t read_port(core_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (reg_write.en && (reg_write.addr == addr)) begin
      return reg_write.data;
    end else begin
      return regs[addr];
    end
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < core_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write.en && (reg_write.addr != '0)) begin
      regs[reg_write.addr] <= reg_write.data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

// ==== decode/decode_stage.sv ====
// ====================
// decode_stage
// input handshake and ID register, register reads,
// RV32I OP / OP-IMM / LUI decode, immediates
// ====================
`timescale 1ns/10ps

module decode_stage (
  input  logic clock,
  input  logic reset,
  input  core_pkg::inst_t inst,
  input  logic inst_valid,
  output logic inst_ready,
  input  logic ex_allowin,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  input  core_pkg::xlen_t rs1_data,
  input  core_pkg::xlen_t rs2_data,
  output core_pkg::uop_t uop,
  output logic uop_valid
);

  core_pkg::inst_t id_inst;
  logic id_valid;
  logic id_allowin;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic is_op;
  logic is_op_imm;
  logic is_lui;
  logic is_shift;
  core_pkg::xlen_t i_imm;
  core_pkg::xlen_t shamt_imm;
  core_pkg::xlen_t u_imm;
  core_pkg::xlen_t imm;
  core_pkg::alu_op_e alu_op;

  assign id_allowin = !id_valid || ex_allowin;
  assign inst_ready = id_allowin;
  assign uop_valid = id_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= inst_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (inst_valid && id_allowin) begin
      id_inst <= inst;
    end
  end

  assign opcode = id_inst[6:0];
  assign funct3 = id_inst[14:12];
  assign funct7 = id_inst[31:25];
  assign rs1_addr = id_inst[19:15];
  assign rs2_addr = id_inst[24:20];

  assign is_op = (opcode == core_pkg::opcode_op);
  assign is_op_imm = (opcode == core_pkg::opcode_op_imm);
  assign is_lui = (opcode == core_pkg::opcode_lui);
  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

  assign i_imm = {{20{id_inst[31]}}, id_inst[31:20]};
  assign shamt_imm = {27'b0, id_inst[24:20]};
  assign u_imm = {id_inst[31:12], 12'b0};
  assign imm = is_lui ? u_imm : (is_shift ? shamt_imm : i_imm);

  always_comb begin
    case (funct3)
      // sub only exists for register-register
      3'b000: alu_op = (is_op && funct7[5]) ? core_pkg::alu_sub : core_pkg::alu_add;
      3'b001: alu_op = core_pkg::alu_sll;
      3'b010: alu_op = core_pkg::alu_slt;
      3'b011: alu_op = core_pkg::alu_sltu;
      3'b100: alu_op = core_pkg::alu_xor;
      3'b101: alu_op = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
      3'b110: alu_op = core_pkg::alu_or;
      default: alu_op = core_pkg::alu_and;
    endcase
    if (is_lui) begin
      alu_op = core_pkg::alu_pass_b;
    end
  end

  always_comb begin
    uop.alu_op = alu_op;
    uop.rs1 = rs1_addr;
    uop.rs2 = rs2_addr;
    uop.rd = id_inst[11:7];
    uop.use_imm = is_op_imm || is_lui;
    // unsupported opcodes retire without a write
    uop.wen = is_op || is_op_imm || is_lui;
    uop.op_a = rs1_data;
    uop.op_b = uop.use_imm ? imm : rs2_data;
    uop.inst = id_inst;
  end

endmodule

// ==== execute/forward_unit.sv ====
// ====================
// forward_unit
// EX operand selection against the
// writeback register's pending result
// ====================
`timescale 1ns/10ps

module forward_unit (
  input  core_pkg::uop_t ex_uop,
  input  core_pkg::commit_t wb_commit,
  input  logic wb_valid,
  output core_pkg::xlen_t op_a,
  output core_pkg::xlen_t op_b
);

  logic wb_writes;
  logic hit_a;
  logic hit_b;

  // x0 results never forward
  assign wb_writes = wb_valid && wb_commit.wen && (wb_commit.rd != '0);

  assign hit_a = wb_writes && (wb_commit.rd == ex_uop.rs1);
  // immediates are never replaced
  assign hit_b = wb_writes && !ex_uop.use_imm && (wb_commit.rd == ex_uop.rs2);

  assign op_a = hit_a ? wb_commit.data : ex_uop.op_a;
  assign op_b = hit_b ? wb_commit.data : ex_uop.op_b;

endmodule

// ==== execute/execute_stage.sv ====
// ====================
// execute_stage
// EX register with forwarding and ALU,
// writeback register, commit port and
// register-file write
// ====================
`timescale 1ns/10ps

module execute_stage (
  input  logic clock,
  input  logic reset,
  input  core_pkg::uop_t uop,
  input  logic uop_valid,
  output logic ex_allowin,
  output core_pkg::commit_t commit,
  output logic commit_valid,
  input  logic commit_ready,
  output core_pkg::reg_write_t reg_write
);

  core_pkg::uop_t ex_uop;
  logic ex_valid;
  core_pkg::commit_t wb_commit;
  logic wb_valid;
  logic wb_allowin;
  logic commit_fire;
  core_pkg::xlen_t fwd_a;
  core_pkg::xlen_t fwd_b;
  core_pkg::xlen_t alu_result;

  assign commit_fire = wb_valid && commit_ready;
  assign wb_allowin = !wb_valid || commit_ready;
  assign ex_allowin = !ex_valid || wb_allowin;

  forward_unit forward_unit0 (
    .ex_uop(ex_uop),
    .wb_commit(wb_commit),
    .wb_valid(wb_valid),
    .op_a(fwd_a),
    .op_b(fwd_b)
  );

  alu alu0 (
    .alu_op(ex_uop.alu_op),
    .a(fwd_a),
    .b(fwd_b),
    .result(alu_result)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      if (ex_allowin) begin
        ex_valid <= uop_valid;
      end
      if (wb_allowin) begin
        wb_valid <= ex_valid;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (uop_valid && ex_allowin) begin
      ex_uop <= uop;
    end
    if (ex_valid && wb_allowin) begin
      wb_commit.wen <= ex_uop.wen;
      wb_commit.rd <= ex_uop.rd;
      wb_commit.data <= alu_result;
      wb_commit.inst <= ex_uop.inst;
    end
  end

  assign commit = wb_commit;
  assign commit_valid = wb_valid;

  // the register file is written in the commit cycle
  always_comb begin
    reg_write.en = commit_fire && wb_commit.wen && (wb_commit.rd != '0);
    reg_write.addr = wb_commit.rd;
    reg_write.data = wb_commit.data;
  end

endmodule

// ==== logic/core_top.sv ====
// ====================
// core_top
// three-stage RV32I integer pipeline: decode,
// register file and execute with writeback
// ====================
`timescale 1ns/10ps

module core_top (
  input  logic clock,
  input  logic reset,
  input  core_pkg::inst_t inst,
  input  logic inst_valid,
  output logic inst_ready,
  output core_pkg::commit_t commit,
  output logic commit_valid,
  input  logic commit_ready
);

  // decode <-> regfile
  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::xlen_t rs1_data;
  core_pkg::xlen_t rs2_data;

  // decode -> execute
  core_pkg::uop_t uop;
  logic uop_valid;
  logic ex_allowin;

  // execute -> regfile
  core_pkg::reg_write_t reg_write;

  decode_stage decode_stage0 (
    .clock(clock),
    .reset(reset),
    .inst(inst),
    .inst_valid(inst_valid),
    .inst_ready(inst_ready),
    .ex_allowin(ex_allowin),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .uop(uop),
    .uop_valid(uop_valid)
  );

  regfile regfile0 (
    .clock(clock),
    .reset(reset),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .reg_write(reg_write)
  );

  execute_stage execute_stage0 (
    .clock(clock),
    .reset(reset),
    .uop(uop),
    .uop_valid(uop_valid),
    .ex_allowin(ex_allowin),
    .commit(commit),
    .commit_valid(commit_valid),
    .commit_ready(commit_ready),
    .reg_write(reg_write)
  );

endmodule

// ==== verification/core_chk.sv ====
// ====================
// core_chk
// golden register model, accepted-instruction queue
// and concurrent assertions on the core ports
// ====================
`timescale 1ns/10ps

module core_chk (
  input logic clock,
  input logic reset,
  input core_pkg::inst_t inst,
  input logic inst_valid,
  input logic inst_ready,
  input core_pkg::commit_t commit,
  input logic commit_valid,
  input logic commit_ready
);

  core_pkg::xlen_t golden [0:core_pkg::reg_count-1];
  core_pkg::inst_t pending [0:7];
  logic [2:0] head;
  logic [2:0] tail;
  logic [3:0] count;
  logic accept_fire;
  logic commit_fire;
  core_pkg::inst_t front;
  logic front_legal;
  core_pkg::xlen_t src_a;
  core_pkg::xlen_t src_b;
  core_pkg::xlen_t exp_data;
  int fail_count = 0;

  // RV32I result of an OP, OP-IMM or LUI word
  function automatic core_pkg::xlen_t rv32i_result(core_pkg::inst_t w, core_pkg::xlen_t x_a,
                                                   core_pkg::xlen_t x_b);
    core_pkg::xlen_t rhs;
    logic [4:0] sh;
    if (w[6:0] == core_pkg::opcode_lui) begin
      return {w[31:12], 12'h000};
    end
    rhs = (w[6:0] == core_pkg::opcode_op) ? x_b : {{20{w[31]}}, w[31:20]};
    sh = rhs[4:0];
    case (w[14:12])
      3'd0: begin
        if ((w[6:0] == core_pkg::opcode_op) && w[30]) begin
          return x_a - rhs;
        end
        return x_a + rhs;
      end
      3'd1: return x_a << sh;
      3'd2: return ($signed(x_a) < $signed(rhs)) ? 32'd1 : 32'd0;
      3'd3: return (x_a < rhs) ? 32'd1 : 32'd0;
      3'd4: return x_a ^ rhs;
      3'd5: begin
        if (w[30]) begin
          return $signed(x_a) >>> sh;
        end
        return x_a >> sh;
      end
      3'd6: return x_a | rhs;
      default: return x_a & rhs;
    endcase
  endfunction

  assign accept_fire = inst_valid && inst_ready;
  assign commit_fire = commit_valid && commit_ready;
  assign front = pending[head];

  always_comb begin
    src_a = (front[19:15] == '0) ? '0 : golden[front[19:15]];
    src_b = (front[24:20] == '0) ? '0 : golden[front[24:20]];
    exp_data = rv32i_result(front, src_a, src_b);
    front_legal = (front[6:0] == core_pkg::opcode_op) || (front[6:0] == core_pkg::opcode_op_imm)
                  || (front[6:0] == core_pkg::opcode_lui);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      for (int i = 0; i < core_pkg::reg_count; i++) begin
        golden[i] <= '0;
      end
    end else begin
      if (accept_fire) begin
        pending[tail] <= inst;
        tail <= tail + 3'd1;
      end
      if (commit_fire) begin
        head <= head + 3'd1;
        // x0 is never written
        if (front_legal && (front[11:7] != '0)) begin
          golden[front[11:7]] <= exp_data;
        end
      end
      count <= count + 4'(accept_fire) - 4'(commit_fire);
    end
  end

  reset_commit_low: assert property (@(posedge clock) reset |=> !commit_valid)
    else begin
      $error("Error at %0t: commit_valid expected 0, got %b", $time, $sampled(commit_valid));
      fail_count++;
    end

  reset_ready_high: assert property (@(posedge clock) reset |=> inst_ready)
    else begin
      $error("Error at %0t: inst_ready expected 1, got %b", $time, $sampled(inst_ready));
      fail_count++;
    end

  commit_in_order: assert property (@(posedge clock) disable iff (reset)
    commit_fire |-> (count != '0) && (commit.inst == front))
    else begin
      $error("Error at %0t: commit.inst expected %h, got %h (queued %0d)", $time,
             $sampled(front), $sampled(commit.inst), $sampled(count));
      fail_count++;
    end

  commit_data_ok: assert property (@(posedge clock) disable iff (reset)
    (commit_fire && front_legal) |-> commit.wen && (commit.data == exp_data))
    else begin
      $error("Error at %0t: commit.data expected %h, got %h (wen %b)", $time,
             $sampled(exp_data), $sampled(commit.data), $sampled(commit.wen));
      fail_count++;
    end

  commit_rd_ok: assert property (@(posedge clock) disable iff (reset)
    (commit_fire && front_legal) |-> (commit.rd == front[11:7]))
    else begin
      $error("Error at %0t: commit.rd expected %0d, got %0d", $time,
             $sampled(front[11:7]), $sampled(commit.rd));
      fail_count++;
    end

  illegal_no_write: assert property (@(posedge clock) disable iff (reset)
    (commit_fire && !front_legal) |-> !commit.wen)
    else begin
      $error("Error at %0t: commit.wen expected 0, got %b", $time, $sampled(commit.wen));
      fail_count++;
    end

  // stalled commit holds
  commit_holds: assert property (@(posedge clock) disable iff (reset)
    (commit_valid && !commit_ready) |=> commit_valid && $stable(commit))
    else begin
      $error("Error at %0t: commit expected %h, got %h (valid %b)", $time,
             $past(commit), $sampled(commit), $sampled(commit_valid));
      fail_count++;
    end

endmodule

bind core_top core_chk core_chk0 (
  .clock(clock),
  .reset(reset),
  .inst(inst),
  .inst_valid(inst_valid),
  .inst_ready(inst_ready),
  .commit(commit),
  .commit_valid(commit_valid),
  .commit_ready(commit_ready)
);

// ==== verification/core_tb.sv ====
// ====================
// core_tb
// clock and reset, directed and random RV32I
// stimulus, commit counting and final verdict
// ====================
`timescale 1ns/10ps

module core_tb;

  localparam int seed = 74;
  localparam int random_count = 200;
  localparam int send_timeout = 100;
  localparam int drain_timeout = 300;

  logic clock;
  logic reset;
  core_pkg::inst_t inst;
  logic inst_valid;
  logic inst_ready;
  core_pkg::commit_t commit;
  logic commit_valid;
  logic commit_ready;

  logic ready_random;
  logic commit_seen;
  int sent_count;
  int commit_count;

  core_top dut0 (
    .clock(clock),
    .reset(reset),
    .inst(inst),
    .inst_valid(inst_valid),
    .inst_ready(inst_ready),
    .commit(commit),
    .commit_valid(commit_valid),
    .commit_ready(commit_ready)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  function automatic core_pkg::inst_t op_word(logic [6:0] f7, core_pkg::reg_addr_t rs2,
                                              core_pkg::reg_addr_t rs1, logic [2:0] f3,
                                              core_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, core_pkg::opcode_op};
  endfunction

  function automatic core_pkg::inst_t op_imm_word(logic [11:0] imm, core_pkg::reg_addr_t rs1,
                                                  logic [2:0] f3, core_pkg::reg_addr_t rd);
    return {imm, rs1, f3, rd, core_pkg::opcode_op_imm};
  endfunction

  function automatic core_pkg::inst_t lui_word(logic [19:0] imm, core_pkg::reg_addr_t rd);
    return {imm, rd, core_pkg::opcode_lui};
  endfunction

  // low registers only, so dependencies are frequent
  function automatic core_pkg::inst_t random_word();
    int kind;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [6:0] major;
    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    kind = $urandom % 8;
    f3 = 3'($urandom % 8);
    rd = 5'($urandom % 8);
    rs1 = 5'($urandom % 8);
    rs2 = 5'($urandom % 8);
    f7 = 7'h00;
    if (((f3 == 3'd0) && (kind < 3)) || (f3 == 3'd5)) begin
      f7 = ($urandom % 2) ? 7'h20 : 7'h00;
    end
    if (kind < 3) begin
      return op_word(f7, rs2, rs1, f3, rd);
    end else if (kind < 6) begin
      if ((f3 == 3'd1) || (f3 == 3'd5)) begin
        return op_imm_word({f7, 5'($urandom)}, rs1, f3, rd);
      end
      return op_imm_word(12'($urandom), rs1, f3, rd);
    end else if (kind == 6) begin
      return lui_word(20'($urandom), rd);
    end
    major = 7'($urandom);
    if ((major == core_pkg::opcode_op) || (major == core_pkg::opcode_op_imm)
        || (major == core_pkg::opcode_lui)) begin
      major = 7'h7f;
    end
    return {25'($urandom), major};
  endfunction

  // holds the word until the edge that takes it
  task automatic send_inst(input core_pkg::inst_t word);
    int waited;
    logic ready_seen;
    inst <= word;
    inst_valid <= 1'b1;
    waited = 0;
    ready_seen = 1'b0;
    while (!ready_seen) begin
      @(negedge clock);
      ready_seen = inst_ready;
      @(posedge clock);
      waited++;
      if (waited > send_timeout) begin
        report_failure("inst_ready stayed low too long, the core accepts no instruction");
      end
    end
    sent_count++;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (commit_count != sent_count) begin
      @(posedge clock);
      waited++;
      if (waited > drain_timeout) begin
        report_failure("the pipeline did not drain, some instructions never committed");
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    if (ready_random) begin
      commit_ready <= ($urandom % 4) != 0;
    end else begin
      commit_ready <= 1'b1;
    end
  end

  always @(negedge clock) begin
    commit_seen = commit_valid && commit_ready;
    if (dut0.core_chk0.fail_count != 0) begin
      report_failure("an assertion on the core ports failed");
    end
  end

  always @(posedge clock) begin
    if (commit_seen) begin
      commit_count <= commit_count + 1;
    end
  end

  initial begin
    void'($urandom(seed));
    reset = 1'b1;
    inst = '0;
    inst_valid = 1'b0;
    commit_ready = 1'b1;
    ready_random = 1'b0;
    sent_count = 0;
    commit_count = 0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    // directed, back to back with dependencies
    send_inst(lui_word(20'h12345, 5'd1));
    send_inst(op_imm_word(12'h678, 5'd1, 3'd0, 5'd1));
    send_inst(op_imm_word(12'hfff, 5'd0, 3'd0, 5'd2));
    send_inst(op_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    send_inst(op_word(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
    send_inst(op_word(7'h00, 5'd1, 5'd2, 3'd1, 5'd5));
    send_inst(op_word(7'h00, 5'd1, 5'd2, 3'd2, 5'd6));
    send_inst(op_word(7'h00, 5'd1, 5'd2, 3'd3, 5'd7));
    send_inst(op_word(7'h00, 5'd1, 5'd2, 3'd4, 5'd8));
    send_inst(op_word(7'h00, 5'd3, 5'd2, 3'd5, 5'd9));
    send_inst(op_word(7'h20, 5'd3, 5'd2, 3'd5, 5'd10));
    send_inst(op_word(7'h00, 5'd2, 5'd1, 3'd6, 5'd11));
    send_inst(op_word(7'h00, 5'd2, 5'd1, 3'd7, 5'd12));
    send_inst(op_imm_word({7'h00, 5'd4}, 5'd1, 3'd1, 5'd13));
    send_inst(op_imm_word({7'h20, 5'd31}, 5'd2, 3'd5, 5'd14));
    send_inst(op_imm_word({7'h00, 5'd3}, 5'd2, 3'd5, 5'd15));
    send_inst(op_imm_word(12'h800, 5'd1, 3'd2, 5'd16));
    send_inst(op_imm_word(12'h800, 5'd1, 3'd3, 5'd17));
    send_inst(op_imm_word(12'h0f0, 5'd1, 3'd4, 5'd18));
    send_inst(op_imm_word(12'h00f, 5'd1, 3'd6, 5'd19));
    send_inst(op_imm_word(12'hf0f, 5'd1, 3'd7, 5'd20));
    send_inst(op_imm_word(12'h005, 5'd1, 3'd0, 5'd0));
    send_inst(op_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd21));
    // load and ecall are outside the kept set
    send_inst(32'h0000_2083);
    send_inst(32'h0000_0073);
    send_inst(op_word(7'h00, 5'd21, 5'd1, 3'd0, 5'd22));

    ready_random <= 1'b1;
    repeat (random_count) begin
      send_inst(random_word());
      if (($urandom % 3) == 0) begin
        inst_valid <= 1'b0;
        repeat (($urandom % 3) + 1) @(posedge clock);
      end
    end
    inst_valid <= 1'b0;
    ready_random <= 1'b0;

    wait_drain();
    repeat (4) @(posedge clock);
    if (commit_count != sent_count) begin
      report_failure($sformatf("Error at %0t: commit_count expected %0d, got %0d", $time,
                               sent_count, commit_count));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== all.f ====
common/core_pkg.sv
logic/alu.sv
logic/regfile.sv
decode/decode_stage.sv
execute/forward_unit.sv
execute/execute_stage.sv
logic/core_top.sv
verification/core_chk.sv
verification/core_tb.sv
